// File: scalar_unit.f
rtl/scalar_pkg.sv
rtl/issue_if.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/scalar_unit.sv
tests/scalar_unit_checker.sv
tests/scalar_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module scalar_unit_tb \
	-f scalar_unit.f -o scalar_unit_sim \
	&& ./obj_dir/scalar_unit_sim | tee sim.log \
	&& grep -qx '>>> PASS' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tests/scalar_unit_tb.sv
//////////////////////////////////////////////////////////////////////
// Loads each table program as 64 words plus one dropped word
// Register contents carry over between programs, only reset clears them
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scalar_unit_tb;

	localparam int clk_period = 40;
	localparam int num_prog   = 3;
	localparam int max_cmd    = 8;
	localparam int loop_count = 5;

	logic               clock;
	logic               reset;
	logic               prog_valid;
	scalar_pkg::instr_t prog_word;
	logic               prog_ack;
	logic               start;
	logic               busy;
	logic               term;
	scalar_pkg::lane_t  lane_en;
	logic               v_cmd_valid;
	scalar_pkg::instr_t v_cmd_word;
	scalar_pkg::data_t  v_cmd_data;

	// Program table with expected vector commands and final lane mask
	scalar_pkg::instr_t prog_tab [num_prog][scalar_pkg::imem_depth];
	string              prog_name [num_prog];
	int                 exp_cnt [num_prog];
	scalar_pkg::data_t  exp_data [num_prog][max_cmd];
	scalar_pkg::instr_t exp_word [num_prog][max_cmd];
	scalar_pkg::lane_t  exp_lane [num_prog];

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	logic        verdict_done;

	scalar_unit dut_i (
		.clock       (clock),
		.reset       (reset),
		.prog_valid  (prog_valid),
		.prog_word   (prog_word),
		.prog_ack    (prog_ack),
		.start       (start),
		.busy        (busy),
		.term        (term),
		.lane_en     (lane_en),
		.v_cmd_valid (v_cmd_valid),
		.v_cmd_word  (v_cmd_word),
		.v_cmd_data  (v_cmd_data)
	);

	bind scalar_unit scalar_unit_checker checker_i (
		.clock       (clock),
		.reset       (reset),
		.prog_valid  (prog_valid),
		.prog_ack    (prog_ack),
		.busy        (busy),
		.term        (term),
		.v_cmd_valid (v_cmd_valid)
	);

	always #(clk_period / 2) clock = ~clock;

	//////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////
	task automatic check_data(input string name, input scalar_pkg::data_t expected,
			input scalar_pkg::data_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input scalar_pkg::instr_t expected,
			input scalar_pkg::instr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_lane(input string name, input scalar_pkg::lane_t expected,
			input scalar_pkg::lane_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////
	// Encoders, operand source and table construction
	//////////////////////////////////////////////////////////////////
	function automatic scalar_pkg::instr_t reg_word(input scalar_pkg::opcode_t op,
			input logic [3:0] d, input logic [3:0] s1, input logic [3:0] s2);
		scalar_pkg::instr_t w;
		w              = '0;
		w.reg_f.opcode = op;
		w.reg_f.dst    = d;
		w.reg_f.src1   = s1;
		w.reg_f.src2   = s2;
		return w;
	endfunction

	function automatic scalar_pkg::instr_t imm_word(input scalar_pkg::opcode_t op,
			input logic [3:0] d, input logic [3:0] s1, input logic [15:0] imm);
		scalar_pkg::instr_t w;
		w              = '0;
		w.imm_f.opcode = op;
		w.imm_f.dst    = d;
		w.imm_f.src1   = s1;
		w.imm_f.imm    = imm;
		return w;
	endfunction

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic scalar_pkg::data_t sext(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic expect_cmd(input int p, input scalar_pkg::data_t d,
			input scalar_pkg::instr_t w);
		exp_data[p][exp_cnt[p]] = d;
		exp_word[p][exp_cnt[p]] = w;
		exp_cnt[p]++;
	endtask

	task automatic build_table();
		logic [15:0]         ra;
		logic [15:0]         rb;
		logic [15:0]         rc;
		scalar_pkg::data_t   a;
		scalar_pkg::data_t   b;
		scalar_pkg::data_t   r;
		scalar_pkg::opcode_t op;
		scalar_pkg::instr_t  w;
		for (int p = 0; p < num_prog; p++) begin
			exp_cnt[p] = 0;
			// Vector commands fill every word behind the halt
			for (int k = 0; k < scalar_pkg::imem_depth; k++)
				prog_tab[p][k] = imm_word(scalar_pkg::op_vcmd, 4'd0, 4'd1, 16'(k));
		end
		ra = rand16();
		rb = rand16();
		rc = rand16();
		a  = sext(ra);
		b  = sext(rb);

		// Each ALU operation followed by a command that reads its result
		prog_name[0]   = "alu";
		prog_tab[0][0] = imm_word(scalar_pkg::op_addi, 4'd1, 4'd0, ra);
		prog_tab[0][1] = imm_word(scalar_pkg::op_addi, 4'd2, 4'd0, rb);
		for (int k = 0; k < 5; k++) begin
			case (k)
				0: begin
					op          = scalar_pkg::op_add;
					r           = a + b;
					exp_lane[0] = r[7:0];
				end
				1: begin
					op = scalar_pkg::op_sub;
					r  = a - b;
				end
				2: begin
					op = scalar_pkg::op_and;
					r  = a & b;
				end
				3: begin
					op = scalar_pkg::op_or;
					r  = a | b;
				end
				default: begin
					op = scalar_pkg::op_xor;
					r  = a ^ b;
				end
			endcase
			prog_tab[0][2 + 2 * k] = reg_word(op, 4'(3 + k), 4'd1, 4'd2);
			w = imm_word(scalar_pkg::op_vcmd, 4'd0, 4'(3 + k), 16'h0100 + 16'(k));
			prog_tab[0][3 + 2 * k] = w;
			expect_cmd(0, r, w);
		end
		// Write to r0 has no effect
		prog_tab[0][12] = imm_word(scalar_pkg::op_addi, 4'd0, 4'd1, 16'h0005);
		w = imm_word(scalar_pkg::op_vcmd, 4'd0, 4'd0, 16'h0105);
		prog_tab[0][13] = w;
		expect_cmd(0, '0, w);
		prog_tab[0][14] = reg_word(scalar_pkg::op_setlane, 4'd0, 4'd3, 4'd0);
		prog_tab[0][15] = reg_word(scalar_pkg::op_halt, 4'd0, 4'd0, 4'd0);

		// Countdown loop; word 5 sits in the squashed slot
		prog_name[1]   = "loop";
		prog_tab[1][0] = imm_word(scalar_pkg::op_addi, 4'd2, 4'd0, 16'h0055);
		prog_tab[1][1] = imm_word(scalar_pkg::op_addi, 4'd1, 4'd0, 16'(loop_count));
		prog_tab[1][2] = imm_word(scalar_pkg::op_vcmd, 4'd0, 4'd1, 16'h0200);
		prog_tab[1][3] = imm_word(scalar_pkg::op_addi, 4'd1, 4'd1, 16'hffff);
		prog_tab[1][4] = imm_word(scalar_pkg::op_bnez, 4'd0, 4'd1, 16'h0002);
		prog_tab[1][5] = imm_word(scalar_pkg::op_vcmd, 4'd0, 4'd2, 16'h0201);
		prog_tab[1][6] = reg_word(scalar_pkg::op_setlane, 4'd0, 4'd2, 4'd0);
		prog_tab[1][7] = reg_word(scalar_pkg::op_halt, 4'd0, 4'd0, 4'd0);
		for (int i = loop_count; i > 0; i--)
			expect_cmd(1, scalar_pkg::data_t'(i), prog_tab[1][2]);
		expect_cmd(1, 32'h55, prog_tab[1][5]);
		exp_lane[1] = 8'h55;

		// Short program right after a halted run
		prog_name[2]   = "restart";
		prog_tab[2][0] = imm_word(scalar_pkg::op_addi, 4'd3, 4'd0, rc);
		prog_tab[2][1] = reg_word(scalar_pkg::op_setlane, 4'd0, 4'd3, 4'd0);
		prog_tab[2][2] = imm_word(scalar_pkg::op_vcmd, 4'd0, 4'd3, 16'h0300);
		prog_tab[2][3] = reg_word(scalar_pkg::op_halt, 4'd0, 4'd0, 4'd0);
		expect_cmd(2, sext(rc), prog_tab[2][2]);
		exp_lane[2] = rc[7:0];
	endtask

	//////////////////////////////////////////////////////////////////
	// Load, start and collect commands until term
	//////////////////////////////////////////////////////////////////
	task automatic run_program(input int p);
		int n;
		n = 0;
		for (int k = 0; k <= scalar_pkg::imem_depth; k++) begin
			@(negedge clock);
			if (k > 0)
				check_bit($sformatf("%s ack %0d", prog_name[p], k - 1), 1'b1, prog_ack);
			prog_valid = 1'b1;
			prog_word  = (k < scalar_pkg::imem_depth) ? prog_tab[p][k] : '1;
		end
		@(negedge clock);
		prog_valid = 1'b0;
		check_bit($sformatf("%s ack of 65th word", prog_name[p]), 1'b0, prog_ack);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		check_bit($sformatf("%s busy at start", prog_name[p]), 1'b1, busy);
		check_bit($sformatf("%s term at start", prog_name[p]), 1'b0, term);
		while (!term) begin
			@(negedge clock);
			if (v_cmd_valid) begin
				if (n < exp_cnt[p]) begin
					check_data($sformatf("%s cmd %0d data", prog_name[p], n),
						exp_data[p][n], v_cmd_data);
					check_word($sformatf("%s cmd %0d word", prog_name[p], n),
						exp_word[p][n], v_cmd_word);
				end
				n++;
			end
		end
		check_data($sformatf("%s command count", prog_name[p]),
			scalar_pkg::data_t'(exp_cnt[p]), scalar_pkg::data_t'(n));
		check_bit($sformatf("%s busy after halt", prog_name[p]), 1'b0, busy);
		check_lane($sformatf("%s lane at halt", prog_name[p]), exp_lane[p], lane_en);
		repeat (4) begin
			@(negedge clock);
			check_bit($sformatf("%s cmd after halt", prog_name[p]), 1'b0, v_cmd_valid);
		end
		check_bit($sformatf("%s term held", prog_name[p]), 1'b1, term);
		check_lane($sformatf("%s lane held", prog_name[p]), exp_lane[p], lane_en);
	endtask

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		start        = 1'b0;
		prog_valid   = 1'b0;
		prog_word    = '0;
		lcg_state    = 32'd18826;
		errors       = 0;
		checks       = 0;
		verdict_done = 1'b0;
		build_table();
		repeat (4) @(negedge clock);
		reset = 1'b0;
		check_bit("reset prog_ack", 1'b0, prog_ack);
		check_bit("reset busy", 1'b0, busy);
		check_bit("reset term", 1'b0, term);
		check_bit("reset v_cmd_valid", 1'b0, v_cmd_valid);
		check_lane("reset lane_en", '0, lane_en);
		for (int p = 0; p < num_prog; p++)
			run_program(p);
		$display("Checks: %0d, errors: %0d", checks, errors);
		verdict_done = 1'b1;
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog sized for load plus run of every program
	initial begin
		#((num_prog * 200 + 100) * clk_period);
		$display("Timeout: the programs did not all finish in time");
		verdict_done = 1'b1;
		$display(">>> FAIL");
		$finish;
	end

	// Run stopped before the verdict, e.g. by a failed assertion
	final begin
		if (!verdict_done)
			$display(">>> FAIL");
	end

endmodule

`default_nettype wire

// File: tests/scalar_unit_checker.sv
//////////////////////////////////////////////////////////////////////
// Bound to scalar_unit; only watches the top-level ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scalar_unit_checker (
	input wire logic clock,
	input wire logic reset,
	input wire logic prog_valid,
	input wire logic prog_ack,
	input wire logic busy,
	input wire logic term,
	input wire logic v_cmd_valid
);

	// Acknowledge only for a word offered in the cycle before
	ack_follows_valid: assert property (@(posedge clock) disable iff (reset)
		prog_ack |-> $past(prog_valid))
		else $error("prog_ack high without prog_valid one cycle earlier");

	// Nothing is issued once the core has terminated
	no_cmd_after_term: assert property (@(posedge clock) disable iff (reset)
		!(v_cmd_valid && term))
		else $error("v_cmd_valid high while term is high");

	// Run state is exclusive
	busy_term_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(busy && term))
		else $error("busy and term high together");

endmodule

`default_nettype wire

// File: rtl/scalar_unit.sv
//////////////////////////////////////////////////////////////////////
// In-order, one instruction per cycle, no stalls
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scalar_unit (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               prog_valid,
	input  wire scalar_pkg::instr_t prog_word,
	output logic                    prog_ack,
	input  wire logic               start,
	output logic                    busy,
	output logic                    term,
	output scalar_pkg::lane_t       lane_en,
	output logic                    v_cmd_valid,
	output scalar_pkg::instr_t      v_cmd_word,
	output scalar_pkg::data_t       v_cmd_data
);

	// Fetch side of the program memory
	logic                  rd_en;
	scalar_pkg::pc_t       rd_addr;
	scalar_pkg::instr_t    rd_word;

	// Register file ports
	scalar_pkg::reg_addr_t rf_addr_a;
	scalar_pkg::reg_addr_t rf_addr_b;
	scalar_pkg::data_t     rf_data_a;
	scalar_pkg::data_t     rf_data_b;
	logic                  rf_wr_en;
	scalar_pkg::reg_addr_t rf_wr_addr;
	scalar_pkg::data_t     rf_wr_data;

	issue_if issue ();

	instr_mem imem_i (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.prog_valid (prog_valid),
		.prog_word  (prog_word),
		.prog_ack   (prog_ack),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_word    (rd_word)
	);

	fetch_unit fetch_i (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_word (rd_word),
		.issue   (issue.fetch),
		.busy    (busy),
		.term    (term)
	);

	reg_file rf_i (
		.clock     (clock),
		.reset     (reset),
		.rd_addr_a (rf_addr_a),
		.rd_addr_b (rf_addr_b),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.wr_en     (rf_wr_en),
		.wr_addr   (rf_wr_addr),
		.wr_data   (rf_wr_data)
	);

	exec_unit exec_i (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue.exec),
		.rd_addr_a   (rf_addr_a),
		.rd_addr_b   (rf_addr_b),
		.rd_data_a   (rf_data_a),
		.rd_data_b   (rf_data_b),
		.wr_en       (rf_wr_en),
		.wr_addr     (rf_wr_addr),
		.wr_data     (rf_wr_data),
		.lane_en     (lane_en),
		.v_cmd_valid (v_cmd_valid),
		.v_cmd_word  (v_cmd_word),
		.v_cmd_data  (v_cmd_data)
	);

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
//////////////////////////////////////////////////////////////////////
// Strobes are combinational on the valid cycle
// Register and lane writes land at the edge closing that cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire logic                  clock,
	input  wire logic                  reset,
	issue_if.exec                      issue,
	output scalar_pkg::reg_addr_t      rd_addr_a,
	output scalar_pkg::reg_addr_t      rd_addr_b,
	input  wire scalar_pkg::data_t     rd_data_a,
	input  wire scalar_pkg::data_t     rd_data_b,
	output logic                       wr_en,
	output scalar_pkg::reg_addr_t      wr_addr,
	output scalar_pkg::data_t          wr_data,
	output scalar_pkg::lane_t          lane_en,
	output logic                       v_cmd_valid,
	output scalar_pkg::instr_t         v_cmd_word,
	output scalar_pkg::data_t          v_cmd_data
);

	scalar_pkg::opcode_t opcode;
	logic                imm_form;
	scalar_pkg::data_t   imm_ext;
	scalar_pkg::pc_t     next_pc;
	logic                alu_wr;
	logic                taken;

	//////////////////////////////////////////////////////////////////
	// Decode through the register or immediate view
	//////////////////////////////////////////////////////////////////
	assign opcode   = issue.word.reg_f.opcode;
	assign imm_form = opcode inside {scalar_pkg::op_addi, scalar_pkg::op_bnez,
		scalar_pkg::op_vcmd};

	// Destination and source 1 sit at the same bits in both views
	assign rd_addr_a = issue.word.reg_f.src1;
	assign rd_addr_b = imm_form ? '0 : issue.word.reg_f.src2;
	assign wr_addr   = issue.word.reg_f.dst;

	// Sign extend the immediate
	assign imm_ext = {{(scalar_pkg::data_w - scalar_pkg::imm_w){issue.word.imm_f.imm[
		scalar_pkg::imm_w-1]}}, issue.word.imm_f.imm};

	// ALU
	always_comb begin
		alu_wr  = 1'b1;
		wr_data = '0;
		case (opcode)
			scalar_pkg::op_add:  wr_data = rd_data_a + rd_data_b;
			scalar_pkg::op_sub:  wr_data = rd_data_a - rd_data_b;
			scalar_pkg::op_and:  wr_data = rd_data_a & rd_data_b;
			scalar_pkg::op_or:   wr_data = rd_data_a | rd_data_b;
			scalar_pkg::op_xor:  wr_data = rd_data_a ^ rd_data_b;
			scalar_pkg::op_addi: wr_data = rd_data_a + imm_ext;
			default:             alu_wr  = 1'b0;
		endcase
	end

	assign wr_en = issue.valid && alu_wr;

	//////////////////////////////////////////////////////////////////
	// Branch and halt
	//////////////////////////////////////////////////////////////////
	assign taken        = issue.valid && (opcode == scalar_pkg::op_bnez) && (rd_data_a != '0);
	assign issue.target = issue.word.imm_f.imm[scalar_pkg::pc_w-1:0];
	assign next_pc      = issue.pc + 1'b1;

	// Taken branch to the next word needs no squash
	assign issue.redirect = taken && (issue.target != next_pc);
	assign issue.halt     = issue.valid && (opcode == scalar_pkg::op_halt);

	// Lane-enable register
	always_ff @(posedge clock) begin
		if (reset)
			lane_en <= '0;
		else if (issue.valid && (opcode == scalar_pkg::op_setlane))
			lane_en <= scalar_pkg::lane_t'(rd_data_a);
	end

	// Vector command carries the whole word and source 1
	assign v_cmd_valid = issue.valid && (opcode == scalar_pkg::op_vcmd);
	assign v_cmd_word  = issue.word;
	assign v_cmd_data  = rd_data_a;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
//////////////////////////////////////////////////////////////////////
// Register 0 ignores writes and always reads zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire scalar_pkg::reg_addr_t rd_addr_a,
	input  wire scalar_pkg::reg_addr_t rd_addr_b,
	output scalar_pkg::data_t          rd_data_a,
	output scalar_pkg::data_t          rd_data_b,
	input  wire logic                  wr_en,
	input  wire scalar_pkg::reg_addr_t wr_addr,
	input  wire scalar_pkg::data_t     wr_data
);

	scalar_pkg::data_t regs [scalar_pkg::num_reg];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < scalar_pkg::num_reg; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational reads see last edge's write
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
//////////////////////////////////////////////////////////////////////
// One fetch per cycle while busy; the word returns one cycle later
// A redirect or halt squashes the single fetch in flight
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               start,
	output logic                    rd_en,
	output scalar_pkg::pc_t         rd_addr,
	input  wire scalar_pkg::instr_t rd_word,
	issue_if.fetch                  issue,
	output logic                    busy,
	output logic                    term
);

	scalar_pkg::pc_t pc;
	scalar_pkg::pc_t fetch_pc;
	logic            pending;

	assign rd_en   = busy;
	assign rd_addr = pc;

	// Returning word goes straight to execute
	assign issue.valid = pending;
	assign issue.word  = rd_word;
	assign issue.pc    = fetch_pc;

	//////////////////////////////////////////////////////////////////
	// Run state and program counter
	//////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			term    <= 1'b0;
			pending <= 1'b0;
			pc      <= '0;
		end else if (start) begin
			busy    <= 1'b1;
			term    <= 1'b0;
			pending <= 1'b0;
			pc      <= '0;
		end else begin
			// Fetch in flight survives only without redirect or halt
			pending <= busy && !issue.redirect && !issue.halt;
			if (issue.halt) begin
				busy <= 1'b0;
				term <= 1'b1;
			end
			if (issue.redirect)
				pc <= issue.target;
			else if (busy)
				pc <= pc + 1'b1;
		end
	end

	// Address of the word now in the memory output register
	always_ff @(posedge clock) begin
		if (rd_en)
			fetch_pc <= pc;
	end

endmodule

`default_nettype wire

// File: rtl/instr_mem.sv
//////////////////////////////////////////////////////////////////////
// Words past the 64th are dropped without acknowledge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               start,
	input  wire logic               prog_valid,
	input  wire scalar_pkg::instr_t prog_word,
	output logic                    prog_ack,
	input  wire logic               rd_en,
	input  wire scalar_pkg::pc_t    rd_addr,
	output scalar_pkg::instr_t      rd_word
);

	scalar_pkg::instr_t          mem [scalar_pkg::imem_depth];
	logic [scalar_pkg::pc_w:0]   wr_cnt;
	logic                        wr_accept;

	assign wr_accept = prog_valid && (wr_cnt != scalar_pkg::imem_depth);

	// Load pointer and acknowledge
	always_ff @(posedge clock) begin
		if (reset || start) begin
			wr_cnt   <= '0;
			prog_ack <= 1'b0;
		end else begin
			prog_ack <= wr_accept;
			if (wr_accept)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// Program array with registered read
	always_ff @(posedge clock) begin
		if (wr_accept && !start)
			mem[scalar_pkg::pc_t'(wr_cnt)] <= prog_word;
		if (rd_en)
			rd_word <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: rtl/issue_if.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle strobes, no back-pressure in either direction
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface issue_if;

	// Forward issue channel
	logic               valid;
	scalar_pkg::instr_t word;
	scalar_pkg::pc_t    pc;

	// Back channel, refers to the word valid in the same cycle
	logic               redirect;
	scalar_pkg::pc_t    target;
	logic               halt;

	modport fetch (
		output valid, word, pc,
		input  redirect, target, halt
	);

	modport exec (
		input  valid, word, pc,
		output redirect, target, halt
	);

endinterface

`default_nettype wire

// File: rtl/scalar_pkg.sv
//////////////////////////////////////////////////////////////////////
// Sizes, opcodes and instruction layouts for the scalar core
// Opcode 0 and codes above op_halt execute as no-ops
//////////////////////////////////////////////////////////////////////
`default_nettype none

package scalar_pkg;

	localparam int data_w     = 32;
	localparam int reg_addr_w = 4;
	localparam int num_reg    = 2 ** reg_addr_w;
	localparam int imem_depth = 64;
	localparam int pc_w       = $clog2(imem_depth);
	localparam int num_lane   = 8;
	localparam int imm_w      = 16;

	typedef logic [data_w-1:0]     data_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [pc_w-1:0]       pc_t;
	typedef logic [num_lane-1:0]   lane_t;

	typedef enum logic [3:0] {
		op_add     = 4'h1,
		op_sub     = 4'h2,
		op_and     = 4'h3,
		op_or      = 4'h4,
		op_xor     = 4'h5,
		op_addi    = 4'h6,
		op_bnez    = 4'h7,
		op_setlane = 4'h8,
		op_vcmd    = 4'h9,
		op_halt    = 4'ha
	} opcode_t;

	// Register form, two register sources
	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   dst;
		reg_addr_t   src1;
		reg_addr_t   src2;
		logic [15:0] unused;
	} reg_form_t;

	// Immediate form, one source and a signed constant
	typedef struct packed {
		opcode_t                 opcode;
		reg_addr_t               dst;
		reg_addr_t               src1;
		logic signed [imm_w-1:0] imm;
		logic [3:0]              unused;
	} imm_form_t;

	typedef union packed {
		reg_form_t reg_f;
		imm_form_t imm_f;
	} instr_t;

endpackage

`default_nettype wire
